/* hdl/id_pkg.sv */
package id_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] inst_t;

  // operations passed on to execute
  typedef enum logic [7:0] {
    ALU_NOP, ALU_OR, ALU_AND, ALU_XOR, ALU_NOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV,
    ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
    ALU_ADDI, ALU_ADDIU, ALU_LW, ALU_SW,
    ALU_J, ALU_JAL, ALU_JR, ALU_JALR, ALU_BEQ
  } alu_op_t;

  // result class, same codes as the execute stage mux
  typedef enum logic [2:0] {
    SEL_NOP         = 3'b000,
    SEL_LOGIC       = 3'b001,
    SEL_SHIFT       = 3'b010,
    SEL_ARITH       = 3'b100,
    SEL_JUMP_BRANCH = 3'b110,
    SEL_LOAD_STORE  = 3'b111
  } alu_sel_t;

  // primary opcodes
  localparam logic [5:0] op_special = 6'b000000;
  localparam logic [5:0] op_j       = 6'b000010;
  localparam logic [5:0] op_jal     = 6'b000011;
  localparam logic [5:0] op_beq     = 6'b000100;
  localparam logic [5:0] op_addi    = 6'b001000;
  localparam logic [5:0] op_addiu   = 6'b001001;
  localparam logic [5:0] op_slti    = 6'b001010;
  localparam logic [5:0] op_sltiu   = 6'b001011;
  localparam logic [5:0] op_andi    = 6'b001100;
  localparam logic [5:0] op_ori     = 6'b001101;
  localparam logic [5:0] op_xori    = 6'b001110;
  localparam logic [5:0] op_lui     = 6'b001111;
  localparam logic [5:0] op_lw      = 6'b100011;
  localparam logic [5:0] op_sw      = 6'b101011;

  // function codes under op_special
  localparam logic [5:0] fn_sll  = 6'b000000;
  localparam logic [5:0] fn_srl  = 6'b000010;
  localparam logic [5:0] fn_sra  = 6'b000011;
  localparam logic [5:0] fn_sllv = 6'b000100;
  localparam logic [5:0] fn_srlv = 6'b000110;
  localparam logic [5:0] fn_srav = 6'b000111;
  localparam logic [5:0] fn_jr   = 6'b001000;
  localparam logic [5:0] fn_jalr = 6'b001001;
  localparam logic [5:0] fn_add  = 6'b100000;
  localparam logic [5:0] fn_addu = 6'b100001;
  localparam logic [5:0] fn_sub  = 6'b100010;
  localparam logic [5:0] fn_subu = 6'b100011;
  localparam logic [5:0] fn_and  = 6'b100100;
  localparam logic [5:0] fn_or   = 6'b100101;
  localparam logic [5:0] fn_xor  = 6'b100110;
  localparam logic [5:0] fn_nor  = 6'b100111;
  localparam logic [5:0] fn_slt  = 6'b101010;
  localparam logic [5:0] fn_sltu = 6'b101011;

  localparam reg_addr_t LINK_REG = 5'd31;

  typedef struct packed {
    logic      rd1_en;
    logic      rd2_en;
    reg_addr_t rd1_addr;
    reg_addr_t rd2_addr;
    reg_addr_t wd;
    logic      wreg;
    alu_op_t   aluop;
    alu_sel_t  alusel;
    word_t     imm;
    logic      illegal;
  } decode_ctrl_t;

  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;
  } fwd_t;

  typedef struct packed {
    alu_op_t   aluop;
    alu_sel_t  alusel;
    word_t     reg1;
    word_t     reg2;
    reg_addr_t wd;
    logic      wreg;
    word_t     link_addr;
    inst_t     inst;
    logic      illegal;
  } id_ex_t;

endpackage

/* hdl/inst_decoder.sv */
`timescale 1ns/10ps

module inst_decoder (
  input  id_pkg::inst_t        inst_i,
  output id_pkg::decode_ctrl_t ctrl_o
);
  import id_pkg::*;

  logic [5:0]  op;
  reg_addr_t   rs;
  reg_addr_t   rt;
  reg_addr_t   rd;
  logic [4:0]  shamt;
  logic [5:0]  funct;
  logic [15:0] imm16;
  word_t       imm_zext;
  word_t       imm_sext;
  logic        const_shift;
  logic        legal;

  assign op    = inst_i[31:26];
  assign rs    = inst_i[25:21];
  assign rt    = inst_i[20:16];
  assign rd    = inst_i[15:11];
  assign shamt = inst_i[10:6];
  assign funct = inst_i[5:0];
  assign imm16 = inst_i[15:0];

  assign imm_zext = {16'h0000, imm16};
  assign imm_sext = {{16{imm16[15]}}, imm16};

  // sll/srl/sra take shamt instead of rs
  assign const_shift = (op == op_special) && (funct inside {fn_sll, fn_srl, fn_sra});

  always_comb begin
    ctrl_o          = '0;
    ctrl_o.rd1_addr = rs;
    ctrl_o.rd2_addr = rt;
    ctrl_o.wd       = rd;
    ctrl_o.aluop    = ALU_NOP;
    legal           = 1'b0;

    // operation lookup
    case (op)
      op_ori:   ctrl_o.aluop = ALU_OR;
      op_andi:  ctrl_o.aluop = ALU_AND;
      op_xori:  ctrl_o.aluop = ALU_XOR;
      op_lui:   ctrl_o.aluop = ALU_OR;
      op_addi:  ctrl_o.aluop = ALU_ADDI;
      op_addiu: ctrl_o.aluop = ALU_ADDIU;
      op_slti:  ctrl_o.aluop = ALU_SLT;
      op_sltiu: ctrl_o.aluop = ALU_SLTU;
      op_lw:    ctrl_o.aluop = ALU_LW;
      op_sw:    ctrl_o.aluop = ALU_SW;
      op_j:     ctrl_o.aluop = ALU_J;
      op_jal:   ctrl_o.aluop = ALU_JAL;
      op_beq:   ctrl_o.aluop = ALU_BEQ;
      op_special: begin
        case (funct)
          fn_sll:  ctrl_o.aluop = ALU_SLL;
          fn_srl:  ctrl_o.aluop = ALU_SRL;
          fn_sra:  ctrl_o.aluop = ALU_SRA;
          fn_sllv: ctrl_o.aluop = ALU_SLLV;
          fn_srlv: ctrl_o.aluop = ALU_SRLV;
          fn_srav: ctrl_o.aluop = ALU_SRAV;
          fn_jr:   ctrl_o.aluop = ALU_JR;
          fn_jalr: ctrl_o.aluop = ALU_JALR;
          fn_add:  ctrl_o.aluop = ALU_ADD;
          fn_addu: ctrl_o.aluop = ALU_ADDU;
          fn_sub:  ctrl_o.aluop = ALU_SUB;
          fn_subu: ctrl_o.aluop = ALU_SUBU;
          fn_and:  ctrl_o.aluop = ALU_AND;
          fn_or:   ctrl_o.aluop = ALU_OR;
          fn_xor:  ctrl_o.aluop = ALU_XOR;
          fn_nor:  ctrl_o.aluop = ALU_NOR;
          fn_slt:  ctrl_o.aluop = ALU_SLT;
          fn_sltu: ctrl_o.aluop = ALU_SLTU;
          default: ctrl_o.aluop = ALU_NOP;
        endcase
      end
      default: ctrl_o.aluop = ALU_NOP;
    endcase

    // final immediate
    case (op)
      op_ori, op_andi, op_xori:             ctrl_o.imm = imm_zext;
      op_lui:                               ctrl_o.imm = {imm16, 16'h0000};
      op_addi, op_addiu, op_slti, op_sltiu: ctrl_o.imm = imm_sext;
      default:                              ctrl_o.imm = '0;
    endcase
    if (const_shift) begin
      ctrl_o.imm = {27'd0, shamt};
    end

    // read enables and destination
    case (op)
      op_special: begin
        if (const_shift) begin
          legal         = (rs == 5'd0);
          ctrl_o.rd2_en = 1'b1;
        end else begin
          legal         = (shamt == 5'd0) && (ctrl_o.aluop != ALU_NOP);
          ctrl_o.rd1_en = 1'b1;
          ctrl_o.rd2_en = !(ctrl_o.aluop inside {ALU_JR, ALU_JALR});
        end
        ctrl_o.wreg = (ctrl_o.aluop != ALU_JR);
      end
      op_ori, op_andi, op_xori, op_lui, op_addi, op_addiu, op_slti, op_sltiu, op_lw: begin
        legal         = 1'b1;
        ctrl_o.rd1_en = 1'b1;
        ctrl_o.wd     = rt;
        ctrl_o.wreg   = 1'b1;
      end
      op_sw, op_beq: begin
        legal         = 1'b1;
        ctrl_o.rd1_en = 1'b1;
        ctrl_o.rd2_en = 1'b1;
      end
      op_j: legal = 1'b1;
      op_jal: begin
        legal       = 1'b1;
        ctrl_o.wd   = LINK_REG;
        ctrl_o.wreg = 1'b1;
      end
      default: legal = 1'b0;
    endcase

    // anything unknown goes down the pipe as a harmless nop
    if (!legal) begin
      ctrl_o.aluop  = ALU_NOP;
      ctrl_o.rd1_en = 1'b0;
      ctrl_o.rd2_en = 1'b0;
      ctrl_o.wreg   = 1'b0;
      ctrl_o.imm    = '0;
    end
    ctrl_o.illegal = !legal;

    case (ctrl_o.aluop)
      ALU_OR, ALU_AND, ALU_XOR, ALU_NOR:                    ctrl_o.alusel = SEL_LOGIC;
      ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV: ctrl_o.alusel = SEL_SHIFT;
      ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
      ALU_ADDI, ALU_ADDIU:                                  ctrl_o.alusel = SEL_ARITH;
      ALU_J, ALU_JAL, ALU_JR, ALU_JALR, ALU_BEQ:            ctrl_o.alusel = SEL_JUMP_BRANCH;
      ALU_LW, ALU_SW:                                       ctrl_o.alusel = SEL_LOAD_STORE;
      default:                                              ctrl_o.alusel = SEL_NOP;
    endcase
  end

endmodule

/* hdl/operand_bypass.sv */
`timescale 1ns/10ps

module operand_bypass (
  input  logic              ctrl_rd_en_i,
  input  id_pkg::reg_addr_t rd_addr_i,
  input  id_pkg::word_t     imm_i,
  input  id_pkg::word_t     rf_data_i,
  input  id_pkg::id_ex_t    held_i,
  input  logic              held_valid_i,
  input  id_pkg::word_t     ex_result_i,
  input  id_pkg::fwd_t      mem_fwd_i,
  output id_pkg::word_t     operand_o,
  output logic              stall_o
);
  import id_pkg::*;

  logic pending_load;
  logic ex_hit;
  logic mem_hit;

  // load in execute has no data yet
  assign pending_load = held_valid_i && (held_i.aluop == ALU_LW)
                        && (held_i.wd == rd_addr_i);
  assign ex_hit       = held_valid_i && held_i.wreg && (held_i.wd == rd_addr_i);
  assign mem_hit      = mem_fwd_i.we && (mem_fwd_i.waddr == rd_addr_i);

  always_comb begin
    stall_o   = 1'b0;
    operand_o = rf_data_i;
    if (!ctrl_rd_en_i) begin
      operand_o = imm_i;
    end else if (rd_addr_i == 5'd0) begin
      // r0 is hardwired, never bypassed
      operand_o = '0;
    end else if (pending_load) begin
      stall_o = 1'b1;
    end else if (ex_hit) begin
      operand_o = ex_result_i;
    end else if (mem_hit) begin
      operand_o = mem_fwd_i.wdata;
    end
  end

  always_comb begin
    assert (ctrl_rd_en_i || !stall_o)
      else $error("stall raised for an operand that is not read");
  end

endmodule

/* hdl/branch_unit.sv */
`timescale 1ns/10ps

module branch_unit (
  input  id_pkg::inst_t   inst_i,
  input  id_pkg::word_t   pc_i,
  input  id_pkg::alu_op_t aluop_i,
  input  id_pkg::word_t   reg1_i,
  input  id_pkg::word_t   reg2_i,
  output logic            branch_flag_o,
  output id_pkg::word_t   branch_addr_o,
  output id_pkg::word_t   link_addr_o
);
  import id_pkg::*;

  word_t pc_plus_4;
  word_t pc_plus_8;
  word_t jump_target;
  word_t beq_target;

  assign pc_plus_4 = pc_i + 32'd4;
  assign pc_plus_8 = pc_i + 32'd8;

  // region of the next pc plus word index
  assign jump_target = {pc_plus_4[31:28], inst_i[25:0], 2'b00};
  assign beq_target  = pc_plus_4 + {{14{inst_i[15]}}, inst_i[15:0], 2'b00};

  always_comb begin
    branch_flag_o = 1'b0;
    branch_addr_o = '0;
    case (aluop_i)
      ALU_J, ALU_JAL: begin
        branch_flag_o = 1'b1;
        branch_addr_o = jump_target;
      end
      ALU_JR, ALU_JALR: begin
        branch_flag_o = 1'b1;
        branch_addr_o = reg1_i;
      end
      ALU_BEQ: begin
        if (reg1_i == reg2_i) begin
          branch_flag_o = 1'b1;
          branch_addr_o = beq_target;
        end
      end
      default: branch_flag_o = 1'b0;
    endcase
  end

  // return address skips the delay slot
  assign link_addr_o = (aluop_i inside {ALU_JAL, ALU_JALR}) ? pc_plus_8 : '0;

endmodule

/* hdl/regfile.sv */
`timescale 1ns/10ps

module regfile (
  input  logic              clk,
  input  logic              reset_i,
  input  id_pkg::fwd_t      wb_i,
  input  id_pkg::reg_addr_t raddr1_i,
  input  id_pkg::reg_addr_t raddr2_i,
  output id_pkg::word_t     rdata1_o,
  output id_pkg::word_t     rdata2_o
);
  import id_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.we && (wb_i.waddr != 5'd0)) begin
      regs[wb_i.waddr] <= wb_i.wdata;
    end
  end

  // same-cycle write is visible to the reader
  function automatic word_t read_port(reg_addr_t addr);
    if (addr == 5'd0) begin
      return '0;
    end else if (wb_i.we && (wb_i.waddr == addr)) begin
      return wb_i.wdata;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rdata1_o = read_port(raddr1_i);
    rdata2_o = read_port(raddr2_i);
  end

  zero_reg_reads: assert property (@(posedge clk) disable iff (reset_i)
    ((raddr1_i != 5'd0) || (rdata1_o == '0)) && ((raddr2_i != 5'd0) || (rdata2_o == '0)))
    else $error("register 0 read back non-zero");

endmodule

/* hdl/id_ex_reg.sv */
`timescale 1ns/10ps

module id_ex_reg #(
  parameter id_pkg::word_t RESET_PC_WORD = '0
) (
  input  logic           clk,
  input  logic           reset_i,
  input  logic           load_i,
  input  logic           stall_i,
  input  id_pkg::id_ex_t next_i,
  output id_pkg::id_ex_t held_o,
  output logic           valid_o
);
  import id_pkg::*;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_o          <= 1'b0;
      held_o.aluop     <= ALU_NOP;
      held_o.alusel    <= SEL_NOP;
      held_o.wd        <= '0;
      held_o.wreg      <= 1'b0;
      held_o.illegal   <= 1'b0;
      held_o.link_addr <= RESET_PC_WORD;
    end else if (load_i && !stall_i) begin
      valid_o <= 1'b1;
      held_o  <= next_i;
    end else begin
      // bubble; operand payload left as is
      valid_o        <= 1'b0;
      held_o.aluop   <= ALU_NOP;
      held_o.alusel  <= SEL_NOP;
      held_o.wreg    <= 1'b0;
      held_o.illegal <= 1'b0;
    end
  end

  bubble_after_stall: assert property (@(posedge clk) disable iff (reset_i)
    stall_i |=> !valid_o)
    else $error("instruction issued in the cycle after a stall");

endmodule

/* hdl/id_stage.sv */
`timescale 1ns/10ps

module id_stage #(
  parameter id_pkg::word_t RESET_PC_WORD = '0
) (
  input  logic           clk,
  input  logic           reset_i,
  input  logic           inst_valid_i,
  input  id_pkg::inst_t  inst_i,
  input  id_pkg::word_t  pc_i,
  input  id_pkg::word_t  ex_result_i,
  input  id_pkg::fwd_t   mem_fwd_i,
  input  id_pkg::fwd_t   wb_i,
  output id_pkg::id_ex_t ex_o,
  output logic           ex_valid_o,
  output logic           branch_flag_o,
  output id_pkg::word_t  branch_addr_o,
  output logic           stall_o
);
  import id_pkg::*;

  decode_ctrl_t ctrl;
  word_t        rf_data1;
  word_t        rf_data2;
  word_t        reg1;
  word_t        reg2;
  logic         stall1;
  logic         stall2;
  logic         taken;
  word_t        link_addr;
  id_ex_t       next;

  inst_decoder u_decoder (
    .inst_i (inst_i),
    .ctrl_o (ctrl)
  );

  regfile u_regfile (
    .clk      (clk),
    .reset_i  (reset_i),
    .wb_i     (wb_i),
    .raddr1_i (ctrl.rd1_addr),
    .raddr2_i (ctrl.rd2_addr),
    .rdata1_o (rf_data1),
    .rdata2_o (rf_data2)
  );

  operand_bypass u_bypass1 (
    .ctrl_rd_en_i (ctrl.rd1_en),
    .rd_addr_i    (ctrl.rd1_addr),
    .imm_i        (ctrl.imm),
    .rf_data_i    (rf_data1),
    .held_i       (ex_o),
    .held_valid_i (ex_valid_o),
    .ex_result_i  (ex_result_i),
    .mem_fwd_i    (mem_fwd_i),
    .operand_o    (reg1),
    .stall_o      (stall1)
  );

  operand_bypass u_bypass2 (
    .ctrl_rd_en_i (ctrl.rd2_en),
    .rd_addr_i    (ctrl.rd2_addr),
    .imm_i        (ctrl.imm),
    .rf_data_i    (rf_data2),
    .held_i       (ex_o),
    .held_valid_i (ex_valid_o),
    .ex_result_i  (ex_result_i),
    .mem_fwd_i    (mem_fwd_i),
    .operand_o    (reg2),
    .stall_o      (stall2)
  );

  branch_unit u_branch (
    .inst_i        (inst_i),
    .pc_i          (pc_i),
    .aluop_i       (ctrl.aluop),
    .reg1_i        (reg1),
    .reg2_i        (reg2),
    .branch_flag_o (taken),
    .branch_addr_o (branch_addr_o),
    .link_addr_o   (link_addr)
  );

  // only a strobed instruction can stall or redirect
  assign stall_o       = inst_valid_i && (stall1 || stall2);
  assign branch_flag_o = inst_valid_i && taken;

  assign next.aluop     = ctrl.aluop;
  assign next.alusel    = ctrl.alusel;
  assign next.reg1      = reg1;
  assign next.reg2      = reg2;
  assign next.wd        = ctrl.wd;
  assign next.wreg      = ctrl.wreg;
  assign next.link_addr = link_addr;
  assign next.inst      = inst_i;
  assign next.illegal   = ctrl.illegal;

  id_ex_reg #(
    .RESET_PC_WORD (RESET_PC_WORD)
  ) u_id_ex (
    .clk     (clk),
    .reset_i (reset_i),
    .load_i  (inst_valid_i),
    .stall_i (stall_o),
    .next_i  (next),
    .held_o  (ex_o),
    .valid_o (ex_valid_o)
  );

endmodule

/* bench/tb_id_stage.sv */
`timescale 1ns/10ps

module tb_id_stage;
  import id_pkg::*;

  logic   clk;
  logic   reset_i;
  logic   inst_valid_i;
  inst_t  inst_i;
  word_t  pc_i;
  word_t  ex_result_i;
  fwd_t   mem_fwd_i;
  fwd_t   wb_i;
  id_ex_t ex_o;
  logic   ex_valid_o;
  logic   branch_flag_o;
  word_t  branch_addr_o;
  logic   stall_o;

  // expected values driven together with the instruction
  id_ex_t exp_word;
  logic   exp_stall;
  logic   exp_bflag;
  word_t  exp_baddr;

  // bench view of the register file and of the held ID/EX entry
  word_t     shadow [32];
  logic      m_held_valid;
  reg_addr_t m_held_wd;
  logic      m_held_wreg;
  logic      m_held_lw;
  integer    seed;

  id_stage #(
    .RESET_PC_WORD (32'h0)
  ) UUT (
    .clk           (clk),
    .reset_i       (reset_i),
    .inst_valid_i  (inst_valid_i),
    .inst_i        (inst_i),
    .pc_i          (pc_i),
    .ex_result_i   (ex_result_i),
    .mem_fwd_i     (mem_fwd_i),
    .wb_i          (wb_i),
    .ex_o          (ex_o),
    .ex_valid_o    (ex_valid_o),
    .branch_flag_o (branch_flag_o),
    .branch_addr_o (branch_addr_o),
    .stall_o       (stall_o)
  );

  always #10 clk = ~clk;

  task automatic abort_run(string line);
    $display("%s", line);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped");
  endtask

  // one cycle after an accepted strobe the stage must hold the model entry
  issue_check: assert property (@(posedge clk) disable iff (reset_i)
    (inst_valid_i && !exp_stall) |=> (ex_valid_o && (ex_o == $past(exp_word))))
    else abort_run($sformatf("Mismatch at %0t: ex_o differs from the decode model", $time));

  stall_check: assert property (@(posedge clk) disable iff (reset_i)
    inst_valid_i |-> (stall_o == exp_stall))
    else abort_run($sformatf("Mismatch at %0t: stall_o is %0b", $time, stall_o));

  bubble_check: assert property (@(posedge clk) disable iff (reset_i)
    (inst_valid_i && exp_stall) |=> !ex_valid_o)
    else abort_run($sformatf("Mismatch at %0t: ex_valid_o high after a stall", $time));

  branch_check: assert property (@(posedge clk) disable iff (reset_i)
    inst_valid_i |-> ((branch_flag_o == exp_bflag) && (!exp_bflag || branch_addr_o == exp_baddr)))
    else abort_run($sformatf("Mismatch at %0t: branch flag or target wrong", $time));

  // without a strobe the stage neither stalls nor redirects
  quiet_check: assert property (@(posedge clk) disable iff (reset_i)
    !inst_valid_i |-> (!stall_o && !branch_flag_o))
    else abort_run($sformatf("Mismatch at %0t: stall or branch raised without a strobe", $time));

  idle_check: assert property (@(posedge clk) disable iff (reset_i)
    !inst_valid_i |=> !ex_valid_o)
    else abort_run($sformatf("Mismatch at %0t: ex_valid_o high without a strobe", $time));

  reset_check: assert property (@(posedge clk) $fell(reset_i) |-> !ex_valid_o)
    else abort_run($sformatf("Mismatch at %0t: ex_valid_o high after reset", $time));

  function automatic inst_t enc_r(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                  logic [4:0] sh, logic [5:0] fn);
    return {op_special, rs, rt, rd, sh, fn};
  endfunction

  function automatic inst_t enc_i(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                  logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic fwd_t make_fwd(logic we, reg_addr_t a, word_t d);
    fwd_t f;
    f.we    = we;
    f.waddr = a;
    f.wdata = d;
    return f;
  endfunction

  function automatic alu_sel_t sel_of(alu_op_t op);
    case (op)
      ALU_OR, ALU_AND, ALU_XOR, ALU_NOR: return SEL_LOGIC;
      ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV: return SEL_SHIFT;
      ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU: return SEL_ARITH;
      ALU_ADDI, ALU_ADDIU: return SEL_ARITH;
      ALU_J, ALU_JAL, ALU_JR, ALU_JALR, ALU_BEQ: return SEL_JUMP_BRANCH;
      ALU_LW, ALU_SW: return SEL_LOAD_STORE;
      default: return SEL_NOP;
    endcase
  endfunction

  // reference decode straight from the instruction set rules
  task automatic decode_model(input inst_t ins, output logic en1, output logic en2,
                              output reg_addr_t wd, output logic wreg,
                              output alu_op_t aop, output word_t imm, output logic ill);
    logic [15:0] i16;
    logic        itype;
    i16   = ins[15:0];
    en1   = 1'b0;
    en2   = 1'b0;
    wd    = ins[15:11];
    wreg  = 1'b0;
    aop   = ALU_NOP;
    imm   = '0;
    ill   = 1'b0;
    itype = 1'b1;
    case (ins[31:26])
      op_ori:   aop = ALU_OR;
      op_andi:  aop = ALU_AND;
      op_xori:  aop = ALU_XOR;
      op_lui:   aop = ALU_OR;
      op_addi:  aop = ALU_ADDI;
      op_addiu: aop = ALU_ADDIU;
      op_slti:  aop = ALU_SLT;
      op_sltiu: aop = ALU_SLTU;
      op_lw:    aop = ALU_LW;
      default:  itype = 1'b0;
    endcase
    case (ins[31:26])
      op_ori, op_andi, op_xori: imm = {16'h0000, i16};
      op_lui: imm = {i16, 16'h0000};
      op_addi, op_addiu, op_slti, op_sltiu: imm = {{16{i16[15]}}, i16};
      default: imm = '0;
    endcase
    if (itype) begin
      en1  = 1'b1;
      wd   = ins[20:16];
      wreg = 1'b1;
    end else begin
      case (ins[31:26])
        op_special: begin
          case (ins[5:0])
            fn_sll:  aop = ALU_SLL;
            fn_srl:  aop = ALU_SRL;
            fn_sra:  aop = ALU_SRA;
            fn_sllv: aop = ALU_SLLV;
            fn_srlv: aop = ALU_SRLV;
            fn_srav: aop = ALU_SRAV;
            fn_jr:   aop = ALU_JR;
            fn_jalr: aop = ALU_JALR;
            fn_add:  aop = ALU_ADD;
            fn_addu: aop = ALU_ADDU;
            fn_sub:  aop = ALU_SUB;
            fn_subu: aop = ALU_SUBU;
            fn_and:  aop = ALU_AND;
            fn_or:   aop = ALU_OR;
            fn_xor:  aop = ALU_XOR;
            fn_nor:  aop = ALU_NOR;
            fn_slt:  aop = ALU_SLT;
            fn_sltu: aop = ALU_SLTU;
            default: ill = 1'b1;
          endcase
          if (aop inside {ALU_SLL, ALU_SRL, ALU_SRA}) begin
            en2 = 1'b1;
            imm = {27'd0, ins[10:6]};
          end else begin
            en1 = 1'b1;
            en2 = !(aop inside {ALU_JR, ALU_JALR});
          end
          wreg = (aop != ALU_JR);
        end
        op_sw: aop = ALU_SW;
        op_beq: aop = ALU_BEQ;
        op_j: aop = ALU_J;
        op_jal: aop = ALU_JAL;
        default: ill = 1'b1;
      endcase
      if (ins[31:26] inside {op_sw, op_beq}) begin
        en1 = 1'b1;
        en2 = 1'b1;
      end
      if (ins[31:26] == op_jal) begin
        wd   = 5'd31;
        wreg = 1'b1;
      end
    end
    if (ill) begin
      en1  = 1'b0;
      en2  = 1'b0;
      wreg = 1'b0;
      aop  = ALU_NOP;
      imm  = '0;
    end
  endtask

  // forwarding priority for one operand
  function automatic word_t operand_model(logic en, reg_addr_t a, word_t imm, word_t exr,
                                          fwd_t mem, output logic st);
    st = 1'b0;
    if (!en) begin
      return imm;
    end else if (a == 5'd0) begin
      return '0;
    end else if (m_held_valid && m_held_lw && (m_held_wd == a)) begin
      st = 1'b1;
      return shadow[a];
    end else if (m_held_valid && m_held_wreg && (m_held_wd == a)) begin
      return exr;
    end else if (mem.we && (mem.waddr == a)) begin
      return mem.wdata;
    end
    return shadow[a];
  endfunction

  task automatic issue(inst_t ins, word_t pc, word_t exr, fwd_t mem);
    logic      en1;
    logic      en2;
    logic      wreg;
    logic      ill;
    logic      s1;
    logic      s2;
    reg_addr_t wd;
    alu_op_t   aop;
    word_t     imm;
    word_t     pc4;
    id_ex_t    e;
    logic      bf;
    word_t     ba;
    decode_model(ins, en1, en2, wd, wreg, aop, imm, ill);
    e.reg1      = operand_model(en1, ins[25:21], imm, exr, mem, s1);
    e.reg2      = operand_model(en2, ins[20:16], imm, exr, mem, s2);
    e.aluop     = aop;
    e.alusel    = sel_of(aop);
    e.wd        = wd;
    e.wreg      = wreg;
    e.link_addr = (aop inside {ALU_JAL, ALU_JALR}) ? pc + 32'd8 : 32'd0;
    e.inst      = ins;
    e.illegal   = ill;
    pc4 = pc + 32'd4;
    bf  = 1'b0;
    ba  = '0;
    if (aop inside {ALU_J, ALU_JAL}) begin
      bf = 1'b1;
      ba = {pc4[31:28], ins[25:0], 2'b00};
    end else if (aop inside {ALU_JR, ALU_JALR}) begin
      bf = 1'b1;
      ba = e.reg1;
    end else if (aop == ALU_BEQ && e.reg1 == e.reg2) begin
      bf = 1'b1;
      ba = pc4 + {{14{ins[15]}}, ins[15:0], 2'b00};
    end
    @(posedge clk);
    inst_valid_i <= 1'b1;
    inst_i       <= ins;
    pc_i         <= pc;
    ex_result_i  <= exr;
    mem_fwd_i    <= mem;
    exp_word     <= e;
    exp_stall    <= s1 | s2;
    exp_bflag    <= bf;
    exp_baddr    <= ba;
    m_held_valid = !(s1 | s2);
    m_held_wd    = wd;
    m_held_wreg  = wreg;
    m_held_lw    = (aop == ALU_LW);
  endtask

  task automatic idle();
    @(posedge clk);
    inst_valid_i <= 1'b0;
    mem_fwd_i    <= '0;
    m_held_valid = 1'b0;
  endtask

  task automatic wait_issued();
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < 8 && !seen; n++) begin
      @(negedge clk);
      seen = ex_valid_o;
    end
    if (!seen) begin
      abort_run("timed out waiting for ex_valid_o");
    end
  endtask

  task automatic write_reg(reg_addr_t a, word_t d);
    @(posedge clk);
    wb_i <= make_fwd(1'b1, a, d);
    shadow[a] = d;
  endtask

  function automatic reg_addr_t rnd_reg();
    return reg_addr_t'($random(seed));
  endfunction

  initial begin
    #2000000;
    abort_run("simulation timeout");
  end

  initial begin
    logic [5:0] r_fns [13];
    logic [5:0] i_ops [8];
    seed         = 32'h90e44056;
    clk          = 1'b0;
    reset_i      = 1'b1;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    pc_i         = '0;
    ex_result_i  = '0;
    mem_fwd_i    = '0;
    wb_i         = '0;
    exp_word     = '0;
    exp_stall    = 1'b0;
    exp_bflag    = 1'b0;
    exp_baddr    = '0;
    m_held_valid = 1'b0;
    m_held_wd    = '0;
    m_held_wreg  = 1'b0;
    m_held_lw    = 1'b0;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    r_fns = '{fn_or, fn_and, fn_xor, fn_nor, fn_add, fn_addu, fn_sub, fn_subu,
              fn_slt, fn_sltu, fn_sllv, fn_srlv, fn_srav};
    i_ops = '{op_ori, op_andi, op_xori, op_addi, op_addiu, op_slti, op_sltiu, op_lui};
    repeat (5) @(posedge clk);
    reset_i <= 1'b0;

    // registers still hold zero after reset
    for (int i = 1; i < 32; i += 2) begin
      issue(enc_r(reg_addr_t'(i), reg_addr_t'(i + 1), 5'd0, 5'd0, fn_or), 32'h0, 32'h0, '0);
      idle();
      wait_issued();
    end

    for (int i = 1; i < 32; i++) begin
      write_reg(reg_addr_t'(i), $random(seed));
    end
    @(posedge clk);
    wb_i <= '0;

    // register forms back to back so some operands hit the held writer
    for (int k = 0; k < 26; k++) begin
      issue(enc_r(rnd_reg(), rnd_reg(), rnd_reg(), 5'd0, r_fns[k % 13]),
            32'h0, $random(seed), '0);
    end
    idle();
    wait_issued();

    // immediate forms and constant shifts
    for (int k = 0; k < 16; k++) begin
      issue(enc_i(i_ops[k % 8], rnd_reg(), rnd_reg(), 16'($random(seed))), 32'h0, 32'h0, '0);
      idle();
      wait_issued();
    end
    issue(enc_r(5'd0, 5'd4, 5'd6, 5'd7, fn_sll), 32'h0, 32'h0, '0);
    issue(enc_r(5'd0, 5'd5, 5'd9, 5'd31, fn_srl), 32'h0, 32'h0, '0);
    issue(enc_r(5'd0, 5'd6, 5'd10, 5'd1, fn_sra), 32'h0, 32'h0, '0);
    issue({6'b111111, 26'h1234567}, 32'h0, 32'h0, '0);
    idle();
    wait_issued();

    // memory-stage forward, then execute wins over memory, then r0
    issue(enc_r(5'd5, 5'd6, 5'd7, 5'd0, fn_add), 32'h0, 32'h0,
          make_fwd(1'b1, 5'd5, 32'hcafe_0005));
    issue(enc_r(5'd7, 5'd2, 5'd8, 5'd0, fn_or), 32'h0, 32'h1111_2222,
          make_fwd(1'b1, 5'd7, 32'h3333_4444));
    issue(enc_r(5'd0, 5'd0, 5'd0, 5'd0, fn_addu), 32'h0, 32'h5555_6666,
          make_fwd(1'b1, 5'd0, 32'h7777_8888));
    issue(enc_r(5'd0, 5'd3, 5'd9, 5'd0, fn_xor), 32'h0, 32'h9999_aaaa,
          make_fwd(1'b1, 5'd0, 32'hbbbb_cccc));
    idle();
    wait_issued();

    // load-use stall and bubble, then the repeat picks the load from memory
    issue(enc_i(op_lw, 5'd3, 5'd8, 16'h0010), 32'h0, 32'h0, '0);
    issue(enc_r(5'd8, 5'd4, 5'd11, 5'd0, fn_add), 32'h0, 32'h0, '0);
    issue(enc_r(5'd8, 5'd4, 5'd11, 5'd0, fn_add), 32'h0, 32'h0,
          make_fwd(1'b1, 5'd8, 32'h0bad_10ad));
    idle();
    wait_issued();
    issue(enc_i(op_lw, 5'd3, 5'd9, 16'h0020), 32'h0, 32'h0, '0);
    issue(enc_r(5'd10, 5'd11, 5'd12, 5'd0, fn_add), 32'h0, 32'h0, '0);
    idle();
    wait_issued();

    // jumps and branches
    issue({op_j, 26'h0123456}, 32'h1040_0100, 32'h0, '0);
    issue({op_jal, 26'h3abcdef}, 32'h2000_0200, 32'h0, '0);
    issue(enc_r(5'd13, 5'd0, 5'd0, 5'd0, fn_jr), 32'h0000_0300, 32'h0, '0);
    issue(enc_r(5'd14, 5'd0, 5'd15, 5'd0, fn_jalr), 32'h0000_0400, 32'h0, '0);
    idle();
    issue(enc_i(op_beq, 5'd12, 5'd12, 16'hfff8), 32'h0000_0500, 32'h0, '0);
    issue(enc_i(op_beq, 5'd12, 5'd13, 16'h0040), 32'h0000_0600, 32'h0, '0);
    issue(enc_i(op_beq, 5'd16, 5'd16, 16'h0040), 32'h0000_0700, 32'h0, '0);
    idle();
    wait_issued();
    repeat (3) @(posedge clk);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* flist.f */
hdl/id_pkg.sv
hdl/inst_decoder.sv
hdl/operand_bypass.sv
hdl/branch_unit.sv
hdl/regfile.sv
hdl/id_ex_reg.sv
hdl/id_stage.sv
bench/tb_id_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ID stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f flist.f \
  --top-module tb_id_stage \
  -o sim_id_stage
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/sim_id_stage 2>&1)
run_status=$?
echo "$sim_output"

if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "TESTBENCH PASSED" <<< "$sim_output"; then
  exit 0
fi
exit 1
